// File: src/cpuPkg.sv
/*
 * Shared widths, instruction encodings and stage-boundary buses of the pipelined CPU.
 * Imported by every stage module and by the testbench.
 */
package cpuPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [14:0] constant_t;

	// primary opcode, instruction bits 31..26
	typedef enum logic [5:0] {
		opNop   = 6'd0,
		opAlu   = 6'd1,
		opAddi  = 6'd2,
		opLoad  = 6'd3,
		opStore = 6'd4
	} opcode_t;

	// register ALU function, instruction bits 3..0
	typedef enum logic [3:0] {
		fnAdd = 4'd0,
		fnSub = 4'd1,
		fnAnd = 4'd2,
		fnOr  = 4'd3,
		fnXor = 4'd4,
		fnSlt = 4'd5
	} aluFunct_t;

	typedef struct packed {
		logic valid;
		logic writeEnable;
		logic memToReg;
		logic memWrite;
		logic useImm;
		aluFunct_t funct;
		regAddr_t dest;
		word_t operandA;
		word_t operandB;
		word_t immediate;
	} decodeToExec_t;

	typedef struct packed {
		logic valid;
		logic writeEnable;
		logic memToReg;
		logic memWrite;
		regAddr_t dest;
		word_t result;
		word_t storeData;
	} execToMem_t;

	// register write, valid only for a nonzero destination
	typedef struct packed {
		logic valid;
		regAddr_t dest;
		word_t data;
	} wbBus_t;

	localparam word_t NOP_INSTR = '0;

endpackage

// File: src/fetchStage.sv
/*
 * Program counter and fetch/decode register.
 * fetchAddr goes to the external program memory, whose word returns in the same cycle.
 */
`timescale 1ns/1ns

module fetchStage import cpuPkg::*; #(
	parameter int PC_WIDTH = 8
) (
	input logic clk,
	input logic reset,
	input logic stall,
	input word_t fetchInstr,
	output logic [PC_WIDTH-1:0] fetchAddr,
	output word_t decodeInstr,
	output logic decodeValid
);

	logic [PC_WIDTH-1:0] pc;

	assign fetchAddr = pc;

	// pc and valid bit hold while decode waits on a load
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			decodeValid <= 1'b0;
		end else if (!stall) begin
			pc <= pc + 1'b1;
			decodeValid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			decodeInstr <= fetchInstr;
		end
	end

endmodule

// File: src/regFile.sv
/*
 * 32-entry register file with two combinational read ports and one write port.
 * A write in the same cycle is returned to a matching read, register 0 reads zero.
 */
`timescale 1ns/1ns

module regFile import cpuPkg::*; (
	input logic clk,
	input regAddr_t rsAddr,
	input regAddr_t rtAddr,
	input wbBus_t write,
	output word_t rsValue,
	output word_t rtValue
);

	word_t regs [0:31];

	function automatic word_t readPort(regAddr_t addr, wbBus_t wr, word_t stored);
		word_t value;
		if (addr == '0) begin
			value = '0;
		end else if (wr.valid && wr.dest == addr) begin
			value = wr.data;
		end else begin
			value = stored;
		end
		return value;
	endfunction

	initial begin
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (write.valid && write.dest != '0) begin
			regs[write.dest] <= write.data;
		end
	end

	assign rsValue = readPort(rsAddr, write, regs[rsAddr]);
	assign rtValue = readPort(rtAddr, write, regs[rtAddr]);

endmodule

// File: src/decodeStage.sv
/*
 * Instruction decode, load-use hazard check and the decode/execute register.
 * Operands are forwarded from memory and writeback while the instruction sits in execute.
 */
`timescale 1ns/1ns

module decodeStage import cpuPkg::*; (
	input logic clk,
	input logic reset,
	input word_t instr,
	input logic instrValid,
	input word_t rsValue,
	input word_t rtValue,
	input execToMem_t execFwd,
	input wbBus_t memFwd,
	input wbBus_t wbFwd,
	output regAddr_t rsAddr,
	output regAddr_t rtAddr,
	output logic stall,
	output decodeToExec_t toExec
);

	opcode_t opcode;
	regAddr_t rsField, rtField, rdField;
	constant_t constField;
	logic usesRs, usesRt;
	logic loadInExec;
	decodeToExec_t nextSlot;
	// decode/execute register, operands as read from the register file
	decodeToExec_t execSlot;
	regAddr_t execRs, execRt;

	// youngest older writer of src wins, register 0 is never forwarded
	function automatic word_t forwardOperand(regAddr_t src, word_t base, execToMem_t ex,
			wbBus_t mem, wbBus_t wb);
		word_t value;
		value = base;
		if (src != '0) begin
			if (ex.valid && ex.writeEnable && !ex.memToReg && ex.dest == src) begin
				value = ex.result;
			end else if (mem.valid && mem.dest == src) begin
				value = mem.data;
			end else if (wb.valid && wb.dest == src) begin
				value = wb.data;
			end
		end
		return value;
	endfunction

	assign opcode = opcode_t'(instr[31:26]);
	assign rsField = instr[24:20];
	assign rtField = instr[19:15];
	assign rdField = instr[14:10];
	assign constField = instr[14:0];

	assign rsAddr = rsField;
	assign rtAddr = rtField;

	always_comb begin
		nextSlot = '0;
		usesRs = 1'b0;
		usesRt = 1'b0;
		nextSlot.funct = fnAdd;
		case (opcode)
			opAlu: begin
				nextSlot.writeEnable = 1'b1;
				nextSlot.funct = aluFunct_t'(instr[3:0]);
				nextSlot.dest = rdField;
				usesRs = 1'b1;
				usesRt = 1'b1;
			end
			opAddi: begin
				nextSlot.writeEnable = 1'b1;
				nextSlot.useImm = 1'b1;
				nextSlot.dest = rtField;
				usesRs = 1'b1;
			end
			opLoad: begin
				nextSlot.writeEnable = 1'b1;
				nextSlot.memToReg = 1'b1;
				nextSlot.useImm = 1'b1;
				nextSlot.dest = rtField;
				usesRs = 1'b1;
			end
			opStore: begin
				nextSlot.memWrite = 1'b1;
				nextSlot.useImm = 1'b1;
				usesRs = 1'b1;
				usesRt = 1'b1;
			end
			// no-op and unknown opcodes write nothing
			default: ;
		endcase
		nextSlot.operandA = rsValue;
		nextSlot.operandB = rtValue;
		nextSlot.immediate = {{17{constField[14]}}, constField};
		nextSlot.valid = instrValid;
	end

	// load still in execute, its data is not ready for this instruction
	assign loadInExec = execSlot.valid && execSlot.memToReg && execSlot.writeEnable
		&& execSlot.dest != '0;
	assign stall = instrValid && loadInExec
		&& ((usesRs && execSlot.dest == rsField) || (usesRt && execSlot.dest == rtField));

	always_ff @(posedge clk) begin
		if (reset) begin
			execSlot.valid <= 1'b0;
		end else begin
			execSlot <= nextSlot;
			// a stalled slot leaves a bubble behind it
			execSlot.valid <= nextSlot.valid && !stall;
		end
	end

	always_ff @(posedge clk) begin
		execRs <= rsField;
		execRt <= rtField;
	end

	always_comb begin
		toExec = execSlot;
		toExec.operandA = forwardOperand(execRs, execSlot.operandA, execFwd, memFwd, wbFwd);
		toExec.operandB = forwardOperand(execRt, execSlot.operandB, execFwd, memFwd, wbFwd);
	end

endmodule

// File: src/executeStage.sv
/*
 * ALU stage and execute/memory register.
 * Second operand is the sign-extended immediate or the rt value.
 */
`timescale 1ns/1ns

module executeStage import cpuPkg::*; (
	input logic clk,
	input logic reset,
	input decodeToExec_t fromDecode,
	output execToMem_t toMem
);

	word_t aluA, aluB;
	word_t aluResult;
	execToMem_t nextMem;

	assign aluA = fromDecode.operandA;
	assign aluB = fromDecode.useImm ? fromDecode.immediate : fromDecode.operandB;

	always_comb begin
		case (fromDecode.funct)
			fnAdd: aluResult = aluA + aluB;
			fnSub: aluResult = aluA - aluB;
			fnAnd: aluResult = aluA & aluB;
			fnOr: aluResult = aluA | aluB;
			fnXor: aluResult = aluA ^ aluB;
			// signed compare
			fnSlt: aluResult = {31'd0, $signed(aluA) < $signed(aluB)};
			default: aluResult = '0;
		endcase
	end

	always_comb begin
		nextMem.valid = fromDecode.valid;
		nextMem.writeEnable = fromDecode.writeEnable;
		nextMem.memToReg = fromDecode.memToReg;
		nextMem.memWrite = fromDecode.memWrite;
		nextMem.dest = fromDecode.dest;
		// for loads and stores this is the effective address
		nextMem.result = aluResult;
		nextMem.storeData = fromDecode.operandB;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			toMem.valid <= 1'b0;
		end else begin
			toMem <= nextMem;
		end
	end

endmodule

// File: src/memoryStage.sv
/*
 * Data memory access and memory/writeback register.
 * Word array indexed by the low address bits, read combinationally, written at the clock edge.
 */
`timescale 1ns/1ns

module memoryStage import cpuPkg::*; #(
	parameter int DMEM_DEPTH_LOG2 = 6
) (
	input logic clk,
	input logic reset,
	input execToMem_t fromExec,
	output wbBus_t memFwd,
	output wbBus_t toWb
);

	localparam int DMEM_DEPTH = 2 ** DMEM_DEPTH_LOG2;

	word_t dmem [0:DMEM_DEPTH-1];
	logic [DMEM_DEPTH_LOG2-1:0] dmemIndex;
	word_t loadData;

	initial begin
		for (int i = 0; i < DMEM_DEPTH; i++) begin
			dmem[i] = '0;
		end
	end

	assign dmemIndex = fromExec.result[DMEM_DEPTH_LOG2-1:0];
	assign loadData = dmem[dmemIndex];

	always_ff @(posedge clk) begin
		if (fromExec.valid && fromExec.memWrite) begin
			dmem[dmemIndex] <= fromExec.storeData;
		end
	end

	// stage value, also the bypass offered to decode
	always_comb begin
		memFwd.valid = fromExec.valid && fromExec.writeEnable && fromExec.dest != '0;
		memFwd.dest = fromExec.dest;
		memFwd.data = fromExec.memToReg ? loadData : fromExec.result;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			toWb.valid <= 1'b0;
		end else begin
			toWb <= memFwd;
		end
	end

endmodule

// File: src/pipelineCpu.sv
/*
 * Five-stage in-order CPU core, top level.
 * Program memory sits outside on fetchAddr/fetchInstr, register writes leave on retire.
 */
`timescale 1ns/1ns

module pipelineCpu import cpuPkg::*; #(
	parameter int PC_WIDTH = 8,
	parameter int DMEM_DEPTH_LOG2 = 6
) (
	input logic clk,
	input logic reset,
	output logic [PC_WIDTH-1:0] fetchAddr,
	input word_t fetchInstr,
	output wbBus_t retire
);

	word_t decodeInstr;
	logic decodeValid;
	logic stall;
	regAddr_t rsAddr, rtAddr;
	word_t rsValue, rtValue;
	decodeToExec_t decodeToExec;
	execToMem_t execToMem;
	wbBus_t memFwd;

	fetchStage #(
		.PC_WIDTH(PC_WIDTH)
	) fetch0 (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.fetchInstr(fetchInstr),
		.fetchAddr(fetchAddr),
		.decodeInstr(decodeInstr),
		.decodeValid(decodeValid)
	);

	// write port is the writeback register itself
	regFile regFile0 (
		.clk(clk),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.write(retire),
		.rsValue(rsValue),
		.rtValue(rtValue)
	);

	decodeStage decode0 (
		.clk(clk),
		.reset(reset),
		.instr(decodeInstr),
		.instrValid(decodeValid),
		.rsValue(rsValue),
		.rtValue(rtValue),
		.execFwd(execToMem),
		.memFwd(memFwd),
		.wbFwd(retire),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.stall(stall),
		.toExec(decodeToExec)
	);

	executeStage execute0 (
		.clk(clk),
		.reset(reset),
		.fromDecode(decodeToExec),
		.toMem(execToMem)
	);

	memoryStage #(
		.DMEM_DEPTH_LOG2(DMEM_DEPTH_LOG2)
	) memory0 (
		.clk(clk),
		.reset(reset),
		.fromExec(execToMem),
		.memFwd(memFwd),
		.toWb(retire)
	);

endmodule

// File: tb/isaModel.svh
/*
 * Random program builder and sequential reference model for the pipelined CPU testbench.
 * Included inside the testbench module, after PROG_LEN and DMEM_DEPTH_LOG2 are declared.
 */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

word_t rngState = 32'hbfd6_52c5;
word_t prog [0:PROG_LEN-1];
word_t modelRegs [0:31];
word_t modelMem [0:(2 ** DMEM_DEPTH_LOG2)-1];
regAddr_t expDest [$];
word_t expData [$];
string expName [$];
int modelCount = 0;

function automatic word_t xorshift32(word_t s);
	word_t x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

function automatic word_t rngNext();
	rngState = xorshift32(rngState);
	return rngState;
endfunction

// rd in bits 14..10, function in bits 3..0
function automatic word_t encodeAlu(aluFunct_t fn, regAddr_t rd, regAddr_t rs, regAddr_t rt);
	return {opAlu, 1'b0, rs, rt, rd, 6'd0, fn};
endfunction

function automatic word_t encodeImm(opcode_t op, regAddr_t rs, regAddr_t rt, constant_t imm);
	return {op, 1'b0, rs, rt, imm};
endfunction

task automatic buildProgram();
	word_t f;
	int unsigned sel;
	regAddr_t rs, rt, rd;
	constant_t imm;
	logic prevLoad;
	regAddr_t prevDest;
	prevLoad = 1'b0;
	prevDest = '0;
	for (int i = 0; i < PROG_LEN; i++) begin
		sel = rngNext() % 32'd100;
		f = rngNext();
		// registers 0..7 only, so dependencies are dense
		rs = {2'b00, f[2:0]};
		rt = {2'b00, f[5:3]};
		rd = {2'b00, f[8:6]};
		// small immediates in -16..15
		imm = {{10{f[13]}}, f[13:9]};
		// often use a load result right away
		if (prevLoad && f[14]) begin
			rs = prevDest;
		end
		prevLoad = 1'b0;
		if (sel < 40) begin
			prog[i] = encodeAlu(aluFunct_t'(f[19:16] % 4'd6), rd, rs, rt);
		end else if (sel < 65) begin
			prog[i] = encodeImm(opAddi, rs, rt, imm);
		end else if (sel < 80) begin
			prog[i] = encodeImm(opLoad, rs, rt, imm);
			prevLoad = 1'b1;
			prevDest = rt;
		end else if (sel < 97) begin
			prog[i] = encodeImm(opStore, rs, rt, imm);
		end else begin
			prog[i] = NOP_INSTR;
		end
	end
endtask

task automatic recordWrite(regAddr_t d, word_t v, string name);
	if (d != '0) begin
		modelRegs[d] = v;
		expDest.push_back(d);
		expData.push_back(v);
		expName.push_back(name);
		modelCount++;
	end
endtask

// runs the program one instruction at a time
task automatic runModel();
	word_t w, a, b, imm, v, addr;
	regAddr_t rs, rt, rd;
	for (int i = 0; i < 32; i++) begin
		modelRegs[i] = '0;
	end
	for (int i = 0; i < 2 ** DMEM_DEPTH_LOG2; i++) begin
		modelMem[i] = '0;
	end
	for (int i = 0; i < PROG_LEN; i++) begin
		w = prog[i];
		rs = w[24:20];
		rt = w[19:15];
		rd = w[14:10];
		a = modelRegs[rs];
		b = modelRegs[rt];
		imm = {{17{w[14]}}, w[14:0]};
		addr = a + imm;
		case (opcode_t'(w[31:26]))
			opAlu: begin
				case (aluFunct_t'(w[3:0]))
					fnAdd: v = a + b;
					fnSub: v = a - b;
					fnAnd: v = a & b;
					fnOr: v = a | b;
					fnXor: v = a ^ b;
					fnSlt: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: v = '0;
				endcase
				recordWrite(rd, v, "alu");
			end
			opAddi: recordWrite(rt, addr, "addi");
			opLoad: recordWrite(rt, modelMem[addr[DMEM_DEPTH_LOG2-1:0]], "load");
			opStore: modelMem[addr[DMEM_DEPTH_LOG2-1:0]] = b;
			default: ;
		endcase
	end
endtask

`endif

// File: tb/pipelineCpuTb.sv
/*
 * Testbench for the pipelined CPU: serves a random program as instruction memory
 * and checks every register write on retire against the reference model.
 */
`timescale 1ns/1ns

module pipelineCpuTb import cpuPkg::*; ();

	localparam int PC_WIDTH = 8;
	localparam int DMEM_DEPTH_LOG2 = 6;
	localparam int PROG_LEN = 200;
	localparam int TIMEOUT_CYCLES = PROG_LEN * 2 + 50;
	// first edge after reset at which instruction 0 can retire
	localparam int FIRST_RETIRE = 4;

	`include "isaModel.svh"

	logic clk;
	logic reset;
	logic [PC_WIDTH-1:0] fetchAddr;
	word_t fetchInstr;
	wbBus_t retire;

	int mismatchCount = 0;
	int otherCount = 0;
	int retireCount = 0;
	int postResetCycles = 0;
	int cycles = 0;
	logic [PC_WIDTH-1:0] lastFetchAddr;

	pipelineCpu #(
		.PC_WIDTH(PC_WIDTH),
		.DMEM_DEPTH_LOG2(DMEM_DEPTH_LOG2)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.fetchAddr(fetchAddr),
		.fetchInstr(fetchInstr),
		.retire(retire)
	);

	function automatic word_t fetchWord(logic [PC_WIDTH-1:0] addr);
		if (addr < PROG_LEN) begin
			return prog[addr];
		end
		return NOP_INSTR;
	endfunction

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// program memory, fetchAddr only moves at a rising edge
	always @(fetchAddr) begin
		fetchInstr <= fetchWord(fetchAddr);
	end

	// retire is stable at the falling edge
	always @(negedge clk) begin
		if (reset) begin
			if (retire.valid) begin
				otherCount++;
				$display("retire.valid was high during reset");
			end
			if (fetchAddr != '0) begin
				otherCount++;
				$display("fetchAddr was not held at 0 during reset");
			end
		end else begin
			postResetCycles++;
			// pc moves by one or holds on a load-use stall
			if (fetchAddr != lastFetchAddr && fetchAddr != lastFetchAddr + 1'b1) begin
				otherCount++;
				$display("fetchAddr jumped from %0d to %0d", lastFetchAddr, fetchAddr);
			end
			if (retire.valid) begin
				retireCount++;
				if (postResetCycles <= FIRST_RETIRE) begin
					otherCount++;
					$display("retirement came earlier than the pipeline depth allows");
				end
				if (retire.dest == '0) begin
					otherCount++;
					$display("a write to register 0 was retired");
				end
				if (expDest.size() == 0) begin
					otherCount++;
					$display("retirement seen while no instruction was left to retire");
				end else begin
					if (retire.dest != expDest[0] || retire.data != expData[0]) begin
						mismatchCount++;
						$display("MISMATCH %s expected r%0d=%08h actual r%0d=%08h",
							expName[0], expDest[0], expData[0], retire.dest, retire.data);
					end
					void'(expDest.pop_front());
					void'(expData.pop_front());
					void'(expName.pop_front());
				end
			end
		end
		lastFetchAddr = fetchAddr;
	end

	initial begin
		reset = 1'b1;
		fetchInstr = NOP_INSTR;
		buildProgram();
		runModel();
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		while (expDest.size() > 0 && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (expDest.size() > 0) begin
			otherCount++;
			$display("timeout after %0d cycles, %0d of %0d retirements never arrived",
				cycles, expDest.size(), modelCount);
		end
		// a few more cycles to catch stray retirements
		repeat (8) @(posedge clk);
		if (retireCount != modelCount) begin
			otherCount++;
			$display("retired %0d instructions, model expects %0d", retireCount, modelCount);
		end
		$display("errors: %0d mismatches, %0d other, %0d of %0d retirements checked",
			mismatchCount, otherCount, retireCount, modelCount);
		if (mismatchCount == 0 && otherCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: pipelineCpu.f
+incdir+tb
src/cpuPkg.sv
src/fetchStage.sv
src/regFile.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/pipelineCpu.sv
tb/pipelineCpuTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the pipelined CPU testbench with Verilator.
# Exit status is nonzero if the build fails or the log reports a failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f pipelineCpu.f --top-module pipelineCpuTb -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	exit 1
fi

if ! grep -q "Test passed" "$LOG"; then
	echo "simulation ended without a verdict"
	exit 1
fi

exit 0
